// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= nabp_tb
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
VERILATOR_FLAGS ?=

SIM_BIN = $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FLIST)) $(wildcard include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) --binary --timing --top-module $(TOP) -f $(FLIST) \
		--Mdir $(BUILD_DIR) $(VERILATOR_FLAGS)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// ==== flist.f ====
+incdir+include
verilog/nabp_cfg_pkg.sv
verilog/nabp_types_pkg.sv
verilog/nabp_state_control.sv
verilog/nabp_shifter.sv
verilog/nabp_filter_mapper.sv
verilog/nabp_sample_store.sv
verilog/nabp_top.sv
test/nabp_tb.sv

// ==== include/nabp_slope_table.svh ====
`ifndef NABP_SLOPE_TABLE_SVH
`define NABP_SLOPE_TABLE_SVH

// per-angle accumulator step in eighths of a sample per image column
//
// the shift phase adds one step per column to the 1.3 accumulator
// and every flip of the integer bit moves the mapper one sample on
//
//   angle   step
//     0       8
//     1       7
//     2       6
//     3       3
//     4       0
//     5       3
//     6       6
//     7       7
//
// a step of 8 walks one sample per column
// a step of 0 keeps the mapper on the first sample of the line
//
// entries in angle order, index 0 first
`define NABP_SLOPE_TABLE '{ \
    4'd8, \
    4'd7, \
    4'd6, \
    4'd3, \
    4'd0, \
    4'd3, \
    4'd6, \
    4'd7  \
}

`endif

// ==== test/nabp_tb.sv ====
`timescale 1ns/1ps

module nabp_tb;

    localparam int FILL_LEN = nabp_cfg_pkg::DEFAULT_FILL_LEN;
    localparam int IMG_SIZE = nabp_cfg_pkg::DEFAULT_IMG_SIZE;
    localparam int NUM_ANGLES = nabp_cfg_pkg::NUM_ANGLES;
    localparam int LINE_DEPTH = nabp_cfg_pkg::LINE_DEPTH;
    localparam int ADDR_W = nabp_cfg_pkg::ADDR_W;
    localparam int ANGLE_W = nabp_cfg_pkg::ANGLE_W;
    localparam int COL_W = nabp_cfg_pkg::COL_W;
    localparam int STORE_WORDS = NUM_ANGLES * LINE_DEPTH;
    localparam int BEATS = NUM_ANGLES * IMG_SIZE;
    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CYCLES = 16;
    localparam int LIVE_WRITES = 16;
    // one angle is fill, shift and a short gap
    localparam int PASS_CYCLES = NUM_ANGLES * (FILL_LEN + IMG_SIZE + 4) + 8;
    localparam int TEST_CYCLES = RESET_CYCLES + IDLE_CYCLES + STORE_WORDS + LIVE_WRITES
                                 + 4 * (PASS_CYCLES + IDLE_CYCLES);
    localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;

    logic                              clk;
    logic                              reset_n;
    logic                              start;
    nabp_types_pkg::host_wr_t          host_wr;
    logic                              host_wr_grant;
    nabp_types_pkg::pixel_t            pixel;
    logic                              busy;
    logic                              done;
    logic [nabp_cfg_pkg::SAMPLE_W-1:0] ref_mem [STORE_WORDS];
    logic [31:0]                       rng_state = 32'h636f_7f9f;
    int                                cycles = 0;

    nabp_top #(
        .FILL_LEN (FILL_LEN),
        .IMG_SIZE (IMG_SIZE)
    ) i_nabp_top (
        .clk           (clk),
        .reset_n       (reset_n),
        .start         (start),
        .host_wr       (host_wr),
        .host_wr_grant (host_wr_grant),
        .pixel         (pixel),
        .busy          (busy),
        .done          (done)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES)
            stop_on_failure($sformatf("Timeout after %0d cycles with the shifter in state %s",
                                      cycles, i_nabp_top.i_shifter.state.name()));
    end

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [nabp_cfg_pkg::SAMPLE_W-1:0] next_sample();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state[nabp_cfg_pkg::SAMPLE_W-1:0];
    endfunction

    // accumulator step per angle in eighths
    function automatic int slope_step(input int angle);
        case (angle)
            0: return 8;
            1: return 7;
            2: return 6;
            3: return 3;
            5: return 3;
            6: return 6;
            7: return 7;
            default: return 0;
        endcase
    endfunction

    task automatic compare_pixel(input string name, input nabp_types_pkg::pixel_t exp_pix,
                                 input nabp_types_pkg::pixel_t act_pix);
        if (act_pix !== exp_pix)
            stop_on_failure($sformatf(
                "Mismatch %s pixel: expected %0b/%0d/%0d/%02h, actual %0b/%0d/%0d/%02h",
                name, exp_pix.valid, exp_pix.angle, exp_pix.col, exp_pix.tap,
                act_pix.valid, act_pix.angle, act_pix.col, act_pix.tap));
    endtask

    task automatic compare_logic(input string name, input string what,
                                 input logic exp_val, input logic act_val);
        if (act_val !== exp_val)
            stop_on_failure($sformatf("Mismatch %s %s: expected %0b, actual %0b",
                                      name, what, exp_val, act_val));
    endtask

    task automatic compare_count(input string name, input string what,
                                 input int exp_val, input int act_val);
        if (act_val != exp_val)
            stop_on_failure($sformatf("Mismatch %s %s: expected %0d, actual %0d",
                                      name, what, exp_val, act_val));
    endtask

    task automatic check_idle(input string name);
        repeat (IDLE_CYCLES)
        begin
            @(negedge clk);
            compare_logic(name, "pixel valid", 1'b0, pixel.valid);
            compare_logic(name, "busy", 1'b0, busy);
            compare_logic(name, "done", 1'b0, done);
            compare_logic(name, "host grant", 1'b1, host_wr_grant);
        end
    endtask

    task automatic load_lines();
        for (int a = 0; a < STORE_WORDS; a++)
        begin
            host_wr.valid = 1'b1;
            host_wr.addr  = ADDR_W'(a);
            host_wr.data  = next_sample();
            ref_mem[a]    = host_wr.data;
            // hold the request until a cycle with grant
            while (!host_wr_grant)
                @(negedge clk);
            @(negedge clk);
        end
        host_wr.valid = 1'b0;
    endtask

    // one full pass over all angles, optionally with host traffic and a stray start
    task automatic run_pass(input string name, input bit live, input bit extra_start);
        nabp_types_pkg::pixel_t exp_pix;
        int beats;
        int angle;
        int col;
        int now;
        int last_beat;
        int grant_low;
        int reads;
        int wr_idx;
        int stalls;
        bit seen_done;
        bit poked;
        bit wr_sent;
        beats = 0;
        now = 0;
        last_beat = 0;
        grant_low = 0;
        wr_idx = 0;
        stalls = 0;
        seen_done = 1'b0;
        poked = 1'b0;
        wr_sent = 1'b0;
        reads = 0;
        for (int a = 0; a < NUM_ANGLES; a++)
            reads += FILL_LEN + (IMG_SIZE * slope_step(a)) / 8;
        host_wr.data = next_sample();
        start = 1'b1;
        while (!seen_done || (live && wr_idx < LIVE_WRITES))
        begin
            @(negedge clk);
            now++;
            start = 1'b0;
            // previous write has committed, new data for the next one
            if (wr_sent)
                host_wr.data = next_sample();
            wr_sent = 1'b0;
            if (pixel.valid)
            begin
                if (beats >= BEATS)
                    stop_on_failure($sformatf("%s: pixel beat after the last angle", name));
                angle = beats / IMG_SIZE;
                col   = beats % IMG_SIZE;
                if (col != 0)
                    compare_logic(name, "beat gap", 1'b1, now == last_beat + 1);
                exp_pix.valid = 1'b1;
                exp_pix.angle = ANGLE_W'(angle);
                exp_pix.col   = COL_W'(col);
                exp_pix.tap   = ref_mem[angle * LINE_DEPTH + (col * slope_step(angle)) / 8];
                compare_pixel(name, exp_pix, pixel);
                last_beat = now;
                beats++;
            end
            if (done)
            begin
                if (seen_done)
                    stop_on_failure($sformatf("%s: done pulsed twice in one run", name));
                compare_count(name, "beats before done", BEATS, beats);
                compare_logic(name, "done after last beat", 1'b1, now == last_beat + 1);
                seen_done = 1'b1;
            end
            if (!host_wr_grant)
                grant_low++;
            if (extra_start && !poked && beats == 2 * IMG_SIZE)
            begin
                compare_logic(name, "busy at stray start", 1'b1, busy);
                start = 1'b1;
                poked = 1'b1;
            end
            // lines 0 and 1 are no longer read once angle 4 is under way
            host_wr.valid = live && beats >= 4 * IMG_SIZE && wr_idx < LIVE_WRITES;
            host_wr.addr  = ADDR_W'((wr_idx / 8) * LINE_DEPTH + wr_idx % 8);
            if (host_wr.valid && host_wr_grant)
            begin
                ref_mem[host_wr.addr] = host_wr.data;
                wr_idx++;
                wr_sent = 1'b1;
            end
            else if (host_wr.valid)
            begin
                stalls++;
            end
        end
        compare_count(name, "cycles without host grant", reads, grant_low);
        if (live && stalls == 0)
            stop_on_failure($sformatf("%s: no host write was held off by a read", name));
        @(negedge clk);
        host_wr.valid = 1'b0;
        compare_logic(name, "done width", 1'b0, done);
        check_idle(name);
    endtask

    task automatic test_angle_zero();
        nabp_types_pkg::pixel_t exp_pix;
        load_lines();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!pixel.valid)
            @(negedge clk);
        for (int j = 0; j < IMG_SIZE; j++)
        begin
            exp_pix.valid = 1'b1;
            exp_pix.angle = '0;
            exp_pix.col   = COL_W'(j);
            exp_pix.tap   = ref_mem[j];
            compare_pixel("angle_zero", exp_pix, pixel);
            @(negedge clk);
        end
        while (!done)
            @(negedge clk);
        check_idle("angle_zero");
    endtask

    initial
    begin
        clk = 1'b0;
        reset_n = 1'b0;
        start = 1'b0;
        host_wr = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        check_idle("reset");
        test_angle_zero();
        run_pass("full_pass", 1'b0, 1'b1);
        run_pass("live_writes", 1'b1, 1'b0);
        run_pass("after_writes", 1'b0, 1'b0);
        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== verilog/nabp_cfg_pkg.sv ====
package nabp_cfg_pkg;

    // angle index, one projection line per angle
    parameter int ANGLE_W = 3;
    parameter int NUM_ANGLES = 2 ** ANGLE_W;

    // filtered sample width
    parameter int SAMPLE_W = 8;

    // store words reserved for each angle line
    parameter int LINE_DEPTH = 16;
    parameter int OFFSET_W = $clog2(LINE_DEPTH);

    // store address is {angle, line offset}
    parameter int ADDR_W = ANGLE_W + OFFSET_W;

    // 1.3 fixed point accumulator of the shift phase
    parameter int ACCU_W = 4;
    parameter int ACCU_FRAC_W = 3;

    // column index carried by a pixel beat
    parameter int COL_W = 3;

    // default geometry
    // fill length plus image size has to fit in one line
    parameter int DEFAULT_FILL_LEN = 8;
    parameter int DEFAULT_IMG_SIZE = 8;

endpackage

// ==== verilog/nabp_filter_mapper.sv ====
`timescale 1ns/1ps

module nabp_filter_mapper #(
    parameter int FILL_LEN = nabp_cfg_pkg::DEFAULT_FILL_LEN
) (
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic [nabp_cfg_pkg::ANGLE_W-1:0]  angle,
    input  logic                              shift_enable,
    input  logic                              phase_fill,
    output nabp_types_pkg::store_rd_t         rd_req,
    input  logic [nabp_cfg_pkg::SAMPLE_W-1:0] rd_data,
    output nabp_types_pkg::pixel_t            pixel
);

    logic [nabp_cfg_pkg::OFFSET_W-1:0] offset;
    logic [nabp_cfg_pkg::OFFSET_W-1:0] rd_offset;
    logic                              fill_en;
    logic                              fill_en_d;
    logic                              fill_first;
    logic                              rd_pending;
    logic [nabp_cfg_pkg::SAMPLE_W-1:0] taps [FILL_LEN];
    logic                              beat_window;
    logic [nabp_cfg_pkg::ANGLE_W-1:0]  beat_angle;
    logic [nabp_cfg_pkg::COL_W-1:0]    col_cnt;

    // first enable of a fill run restarts the line
    assign fill_en    = phase_fill && shift_enable;
    assign fill_first = fill_en && !fill_en_d;
    assign rd_offset  = fill_first ? '0 : offset;

    assign rd_req.valid = shift_enable;
    assign rd_req.addr  = {angle, rd_offset};

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            offset      <= '0;
            fill_en_d   <= 1'b0;
            rd_pending  <= 1'b0;
            beat_window <= 1'b0;
            col_cnt     <= '0;
            pixel.valid <= 1'b0;
        end
        else
        begin
            fill_en_d  <= fill_en;
            rd_pending <= shift_enable;
            if (shift_enable)
                offset <= rd_offset + 1'b1;
            // taps lag the shift phase by one cycle
            beat_window <= !phase_fill;
            col_cnt     <= beat_window ? col_cnt + 1'b1 : '0;
            pixel.valid <= beat_window;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_pending)
        begin
            for (int i = 0; i < FILL_LEN - 1; i++)
                taps[i] <= taps[i + 1];
            taps[FILL_LEN-1] <= rd_data;
        end
        beat_angle  <= angle;
        pixel.angle <= beat_angle;
        pixel.col   <= col_cnt;
        // oldest entry is the current tap
        pixel.tap   <= taps[0];
    end

endmodule

// ==== verilog/nabp_sample_store.sv ====
`timescale 1ns/1ps

module nabp_sample_store (
    input  logic                              clk,
    input  logic                              reset_n,
    input  nabp_types_pkg::host_wr_t          host_wr,
    output logic                              host_wr_grant,
    input  nabp_types_pkg::store_rd_t         rd_req,
    output logic [nabp_cfg_pkg::SAMPLE_W-1:0] rd_data
);

    localparam int DEPTH = 2 ** nabp_cfg_pkg::ADDR_W;

    logic [nabp_cfg_pkg::SAMPLE_W-1:0] mem [DEPTH];
    logic [nabp_cfg_pkg::ADDR_W-1:0]   port_addr;
    logic                              port_we;

    // mapper reads own the port, host writes take idle cycles
    assign host_wr_grant = !rd_req.valid;
    assign port_we = host_wr.valid && host_wr_grant;

    // one shared address for both requesters
    assign port_addr = rd_req.valid ? rd_req.addr : host_wr.addr;

    always_ff @(posedge clk)
    begin
        if (port_we)
            mem[port_addr] <= host_wr.data;
    end

    // registered read, zero until the first access
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            rd_data <= '0;
        else if (rd_req.valid)
            rd_data <= mem[port_addr];
    end

endmodule

// ==== verilog/nabp_shifter.sv ====
`timescale 1ns/1ps

`include "nabp_slope_table.svh"

module nabp_shifter #(
    parameter int FILL_LEN = nabp_cfg_pkg::DEFAULT_FILL_LEN,
    parameter int IMG_SIZE = nabp_cfg_pkg::DEFAULT_IMG_SIZE
) (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic [nabp_cfg_pkg::ANGLE_W-1:0] angle,
    input  logic                             fill_kick,
    input  logic                             shift_kick,
    output logic                             fill_done,
    output logic                             shift_done,
    output logic                             shift_enable,
    output logic                             phase_fill
);

    localparam int FILL_CNT_W = $clog2(FILL_LEN + 1);
    localparam int SHIFT_CNT_W = $clog2(IMG_SIZE + 1);
    localparam logic [nabp_cfg_pkg::ACCU_W-1:0] STEP_TABLE [nabp_cfg_pkg::NUM_ANGLES] =
        `NABP_SLOPE_TABLE;

    nabp_types_pkg::shifter_state_e state;
    nabp_types_pkg::shifter_state_e next_state;

    logic [FILL_CNT_W-1:0]             fill_cnt;
    logic [SHIFT_CNT_W-1:0]            shift_cnt;
    logic [nabp_cfg_pkg::ACCU_W-1:0]   accu;
    logic [nabp_cfg_pkg::ACCU_W-1:0]   accu_next;
    logic [nabp_cfg_pkg::ACCU_W-1:0]   step;
    logic                              in_fill;
    logic                              in_shift;
    logic                              boundary;

    assign in_fill  = (state == nabp_types_pkg::fill);
    assign in_shift = (state == nabp_types_pkg::shift);

    // angle is held steady by the controller for the whole shift phase
    assign step = STEP_TABLE[angle];

    // accumulator wraps freely, only the integer bit matters
    assign accu_next = accu + step;
    assign boundary  = (accu[nabp_cfg_pkg::ACCU_FRAC_W] != accu_next[nabp_cfg_pkg::ACCU_FRAC_W]);

    assign fill_done  = in_fill && (fill_cnt == FILL_CNT_W'(FILL_LEN - 1));
    assign shift_done = in_shift && (shift_cnt == SHIFT_CNT_W'(IMG_SIZE - 1));

    // every fill cycle shifts, shift cycles only on a boundary crossing
    assign shift_enable = in_fill || (in_shift && boundary);

    // low only while the shift phase runs
    assign phase_fill = !in_shift;

    always_comb
    begin
        next_state = state;
        case (state)
            nabp_types_pkg::ready:
                if (fill_kick)
                    next_state = nabp_types_pkg::fill;
            nabp_types_pkg::fill:
                if (fill_done)
                    next_state = nabp_types_pkg::fill_done;
            nabp_types_pkg::fill_done:
                if (shift_kick)
                    next_state = nabp_types_pkg::shift;
            nabp_types_pkg::shift:
                if (shift_done)
                    next_state = nabp_types_pkg::ready;
            default:
                next_state = nabp_types_pkg::ready;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state     <= nabp_types_pkg::ready;
            fill_cnt  <= '0;
            shift_cnt <= '0;
            accu      <= '0;
        end
        else
        begin
            state     <= next_state;
            fill_cnt  <= in_fill ? fill_cnt + 1'b1 : '0;
            shift_cnt <= in_shift ? shift_cnt + 1'b1 : '0;
            accu      <= in_shift ? accu_next : '0;
        end
    end

endmodule

// ==== verilog/nabp_state_control.sv ====
`timescale 1ns/1ps

module nabp_state_control (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             start,
    input  logic                             fill_done,
    input  logic                             shift_done,
    output logic [nabp_cfg_pkg::ANGLE_W-1:0] angle,
    output logic                             fill_kick,
    output logic                             shift_kick,
    output logic                             busy,
    output logic                             done
);

    // beats trail shift_done by the mapper pipeline
    localparam int DRAIN_CYCLES = 2;

    typedef enum logic [1:0] {
        idle       = 2'd0,
        wait_fill  = 2'd1,
        wait_shift = 2'd2,
        drain      = 2'd3
    } ctrl_state_e;

    ctrl_state_e state;
    logic [1:0]  drain_cnt;
    logic        last_angle;

    assign last_angle = &angle;
    assign busy = (state != idle);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state      <= idle;
            angle      <= '0;
            fill_kick  <= 1'b0;
            shift_kick <= 1'b0;
            done       <= 1'b0;
            drain_cnt  <= '0;
        end
        else
        begin
            // kicks and done are single cycle pulses
            fill_kick  <= 1'b0;
            shift_kick <= 1'b0;
            done       <= 1'b0;
            case (state)
                idle:
                begin
                    if (start)
                    begin
                        angle     <= '0;
                        fill_kick <= 1'b1;
                        state     <= wait_fill;
                    end
                end
                wait_fill:
                begin
                    if (fill_done)
                    begin
                        shift_kick <= 1'b1;
                        state      <= wait_shift;
                    end
                end
                wait_shift:
                begin
                    if (shift_done)
                    begin
                        if (last_angle)
                        begin
                            drain_cnt <= 2'(DRAIN_CYCLES - 1);
                            state     <= drain;
                        end
                        else
                        begin
                            // next line, angle settles with the kick
                            angle     <= angle + 1'b1;
                            fill_kick <= 1'b1;
                            state     <= wait_fill;
                        end
                    end
                end
                drain:
                begin
                    if (drain_cnt == '0)
                    begin
                        done  <= 1'b1;
                        state <= idle;
                    end
                    else
                    begin
                        drain_cnt <= drain_cnt - 1'b1;
                    end
                end
                default:
                begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

// ==== verilog/nabp_top.sv ====
`timescale 1ns/1ps

module nabp_top #(
    parameter int FILL_LEN = nabp_cfg_pkg::DEFAULT_FILL_LEN,
    parameter int IMG_SIZE = nabp_cfg_pkg::DEFAULT_IMG_SIZE
) (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     start,
    input  nabp_types_pkg::host_wr_t host_wr,
    output logic                     host_wr_grant,
    output nabp_types_pkg::pixel_t   pixel,
    output logic                     busy,
    output logic                     done
);

    logic [nabp_cfg_pkg::ANGLE_W-1:0]  angle;
    logic                              fill_kick;
    logic                              shift_kick;
    logic                              fill_done;
    logic                              shift_done;
    logic                              shift_enable;
    logic                              phase_fill;
    nabp_types_pkg::store_rd_t         rd_req;
    logic [nabp_cfg_pkg::SAMPLE_W-1:0] rd_data;

    nabp_state_control i_state_control (
        .clk        (clk),
        .reset_n    (reset_n),
        .start      (start),
        .fill_done  (fill_done),
        .shift_done (shift_done),
        .angle      (angle),
        .fill_kick  (fill_kick),
        .shift_kick (shift_kick),
        .busy       (busy),
        .done       (done)
    );

    nabp_shifter #(
        .FILL_LEN (FILL_LEN),
        .IMG_SIZE (IMG_SIZE)
    ) i_shifter (
        .clk          (clk),
        .reset_n      (reset_n),
        .angle        (angle),
        .fill_kick    (fill_kick),
        .shift_kick   (shift_kick),
        .fill_done    (fill_done),
        .shift_done   (shift_done),
        .shift_enable (shift_enable),
        .phase_fill   (phase_fill)
    );

    nabp_filter_mapper #(
        .FILL_LEN (FILL_LEN)
    ) i_filter_mapper (
        .clk          (clk),
        .reset_n      (reset_n),
        .angle        (angle),
        .shift_enable (shift_enable),
        .phase_fill   (phase_fill),
        .rd_req       (rd_req),
        .rd_data      (rd_data),
        .pixel        (pixel)
    );

    nabp_sample_store i_sample_store (
        .clk           (clk),
        .reset_n       (reset_n),
        .host_wr       (host_wr),
        .host_wr_grant (host_wr_grant),
        .rd_req        (rd_req),
        .rd_data       (rd_data)
    );

endmodule

// ==== verilog/nabp_types_pkg.sv ====
package nabp_types_pkg;

    // host write request into the sample store
    typedef struct packed {
        logic                              valid;
        logic [nabp_cfg_pkg::ADDR_W-1:0]   addr;
        logic [nabp_cfg_pkg::SAMPLE_W-1:0] data;
    } host_wr_t;

    // mapper read request, data returns one cycle later
    typedef struct packed {
        logic                            valid;
        logic [nabp_cfg_pkg::ADDR_W-1:0] addr;
    } store_rd_t;

    // one output beat of the mapper
    typedef struct packed {
        logic                              valid;
        logic [nabp_cfg_pkg::ANGLE_W-1:0]  angle;
        logic [nabp_cfg_pkg::COL_W-1:0]    col;
        logic [nabp_cfg_pkg::SAMPLE_W-1:0] tap;
    } pixel_t;

    // shifter phases
    typedef enum logic [1:0] {
        ready     = 2'd0,
        fill      = 2'd1,
        fill_done = 2'd2,
        shift     = 2'd3
    } shifter_state_e;

endpackage
